// File: project.f
verilog/regfile_pkg.sv
verilog/write_pipe.sv
verilog/preg_ram.sv
verilog/read_bypass.sv
verilog/operand_port.sv
verilog/retire_unit.sv
verilog/regfile_top.sv
tests/regfile_chk.sv
tests/regfile_tb.sv

// File: tests/regfile_tb.sv
module regfile_tb;

  localparam int num_read  = 2;
  localparam int num_write = 2;
  localparam int max_rows  = 32;

  logic                                   clk;
  logic                                   rst;
  logic [num_write-1:0]                   wr_en;
  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr;
  regfile_pkg::data_t      [num_write-1:0] wr_data;
  regfile_pkg::preg_addr_t [num_read-1:0]  rd_addr;
  logic [num_read-1:0]                    rd_const_en;
  regfile_pkg::data_t      [num_read-1:0]  rd_const;
  logic [num_read-1:0]                    rd_arch;
  regfile_pkg::areg_addr_t [num_read-1:0]  rd_arch_addr;
  regfile_pkg::data_t      [num_read-1:0]  rd_data;
  logic                                   ret_en;
  regfile_pkg::preg_addr_t                 ret_preg;
  regfile_pkg::areg_addr_t                 ret_areg;

  // one row of stimulus and expected data per cycle.
  string                                  t_name [max_rows];
  logic [num_write-1:0]                   t_wr_en [max_rows];
  regfile_pkg::preg_addr_t [num_write-1:0] t_wr_addr [max_rows];
  regfile_pkg::data_t      [num_write-1:0] t_wr_data [max_rows];
  regfile_pkg::preg_addr_t [num_read-1:0]  t_rd_addr [max_rows];
  logic [num_read-1:0]                    t_const_en [max_rows];
  regfile_pkg::data_t      [num_read-1:0]  t_const [max_rows];
  logic [num_read-1:0]                    t_arch [max_rows];
  regfile_pkg::areg_addr_t [num_read-1:0]  t_arch_addr [max_rows];
  logic                                   t_ret_en [max_rows];
  regfile_pkg::preg_addr_t                 t_ret_preg [max_rows];
  regfile_pkg::areg_addr_t                 t_ret_areg [max_rows];
  regfile_pkg::data_t      [num_read-1:0]  t_exp [max_rows];
  regfile_pkg::data_t                      t_ret_val [max_rows];

  regfile_pkg::data_t pmodel [regfile_pkg::num_pregs]; // shadow of the physical file.
  regfile_pkg::data_t amodel [regfile_pkg::num_aregs];
  int                 n_rows;
  bit                 table_done;
  int                 errors;

  regfile_top #(.num_read(num_read), .num_write(num_write)) u_dut (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .rd_const_en  (rd_const_en),
    .rd_const     (rd_const),
    .rd_arch      (rd_arch),
    .rd_arch_addr (rd_arch_addr),
    .rd_data      (rd_data),
    .ret_en       (ret_en),
    .ret_preg     (ret_preg),
    .ret_areg     (ret_areg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input regfile_pkg::data_t expected,
                             input regfile_pkg::data_t actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // appends one row and works out its expected read data.
  task automatic add_row(input string name, input logic [1:0] wen, input int wa0,
                         input int wa1, input int ra0, input int ra1,
                         input logic [1:0] cen, input logic [1:0] arch, input int aa0,
                         input int aa1, input logic ren, input int rp, input int rareg);
    int n;
    n = n_rows;
    t_name[n]      = name;
    t_wr_en[n]     = wen;
    t_wr_addr[n]   = {regfile_pkg::preg_addr_t'(wa1), regfile_pkg::preg_addr_t'(wa0)};
    t_wr_data[n]   = {$urandom, $urandom};
    t_rd_addr[n]   = {regfile_pkg::preg_addr_t'(ra1), regfile_pkg::preg_addr_t'(ra0)};
    t_const_en[n]  = cen;
    t_const[n]     = {$urandom, $urandom};
    t_arch[n]      = arch;
    t_arch_addr[n] = {regfile_pkg::areg_addr_t'(aa1), regfile_pkg::areg_addr_t'(aa0)};
    t_ret_en[n]    = ren;
    t_ret_preg[n]  = rp;
    t_ret_areg[n]  = rareg;
    if (n >= 2 && t_ret_en[n-2]) begin
      amodel[t_ret_areg[n-2]] = t_ret_val[n-2]; // visible two rows after the retire.
    end
    for (int w = 0; w < num_write; w++) begin
      if (wen[w]) pmodel[t_wr_addr[n][w]] = t_wr_data[n][w];
    end
    t_ret_val[n] = pmodel[t_ret_preg[n]];
    for (int p = 0; p < num_read; p++) begin
      if (cen[p]) t_exp[n][p] = t_const[n][p];
      else if (arch[p]) t_exp[n][p] = amodel[t_arch_addr[n][p]];
      else t_exp[n][p] = pmodel[t_rd_addr[n][p]];
    end
    n_rows++;
  endtask

  task automatic drive_row(input int r);
    wr_en        = t_wr_en[r];
    wr_addr      = t_wr_addr[r];
    wr_data      = t_wr_data[r];
    rd_addr      = t_rd_addr[r];
    rd_const_en  = t_const_en[r];
    rd_const     = t_const[r];
    rd_arch      = t_arch[r];
    rd_arch_addr = t_arch_addr[r];
    ret_en       = t_ret_en[r];
    ret_preg     = t_ret_preg[r];
    ret_areg     = t_ret_areg[r];
  endtask

  task automatic drive_idle();
    wr_en        = '0;
    wr_addr      = '0;
    wr_data      = '0;
    rd_addr      = '0;
    rd_const_en  = '0;
    rd_const     = '0;
    rd_arch      = '0;
    rd_arch_addr = '0;
    ret_en       = 1'b0;
    ret_preg     = '0;
    ret_areg     = '0;
  endtask

  task automatic build_table();
    for (int i = 0; i < regfile_pkg::num_pregs; i++) pmodel[i] = 'x;
    for (int i = 0; i < regfile_pkg::num_aregs; i++) amodel[i] = '0;
    add_row("arch_reset",  2'b00,  0,  0,  0,  0, 2'b00, 2'b11, 0, 5, 0,  0, 0);
    add_row("same_edge",   2'b11, 10, 11, 10, 11, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("stage1",      2'b11, 12, 20, 10, 11, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("stage2",      2'b11, 21, 22, 10, 12, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("array",       2'b00,  0,  0, 10, 11, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("same_addr",   2'b11, 30, 30, 30, 30, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("later_wr",    2'b01, 40,  0, 30, 40, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("over_s1",     2'b10,  0, 40, 40, 30, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("over_s2",     2'b01, 40,  0, 40, 22, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("layers",      2'b00,  0,  0, 40, 30, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("layers_late", 2'b00,  0,  0, 40, 12, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("array_late",  2'b00,  0,  0, 40, 20, 2'b00, 2'b00, 0, 0, 0,  0, 0);
    add_row("const",       2'b00,  0,  0, 40, 30, 2'b11, 2'b01, 3, 0, 0,  0, 0);
    add_row("const_wr",    2'b01, 50,  0, 50, 50, 2'b01, 2'b00, 0, 0, 0,  0, 0);
    add_row("retire",      2'b01, 55,  0, 55, 55, 2'b00, 2'b01, 3, 0, 1, 55, 3);
    add_row("retire_wait", 2'b00,  0,  0, 55, 55, 2'b00, 2'b11, 3, 3, 0,  0, 0);
    add_row("retire_arch", 2'b00,  0,  0, 55, 55, 2'b00, 2'b11, 3, 3, 1, 10, 7);
    add_row("retire_mix",  2'b00,  0,  0, 55, 55, 2'b00, 2'b01, 7, 3, 0,  0, 0);
    add_row("retire_arr",  2'b00,  0,  0, 55, 11, 2'b00, 2'b11, 7, 0, 0,  0, 0);
    add_row("idle",        2'b00,  0,  0, 10, 11, 2'b00, 2'b00, 0, 0, 0,  0, 0);
  endtask

  initial begin
    wait (table_done);
    #(n_rows * 4 * 2 + 100);
    $display("run timed out before all rows were checked");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    errors     = 0;
    n_rows     = 0;
    table_done = 1'b0;
    drive_idle();
    void'($urandom(60006));
    build_table();
    table_done = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    for (int r = 0; r <= n_rows; r++) begin
      @(posedge clk);
      #1;
      if (r > 0) begin
        for (int p = 0; p < num_read; p++) begin
          check_value($sformatf("%s port %0d", t_name[r-1], p), t_exp[r-1][p], rd_data[p]);
        end
      end
      if (r < n_rows) drive_row(r);
      else drive_idle();
    end
    $display("rows %0d errors %0d", n_rows, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/regfile_chk.sv
module regfile_chk #(
  parameter int num_write = 2
) (
  input logic                                   clk,
  input logic                                   rst,
  input logic [num_write-1:0]                   s1_en,
  input regfile_pkg::preg_addr_t [num_write-1:0] s1_addr,
  input logic [num_write-1:0]                   s2_en,
  input regfile_pkg::preg_addr_t [num_write-1:0] s2_addr
);

  a_reset_clears: assert property (@(posedge clk) rst |=> (s1_en == '0 && s2_en == '0))
    else $error("stage enables still set one cycle after reset");

  for (genvar w = 0; w < num_write; w++) begin : g_port
    a_s1_moves: assert property (@(posedge clk) disable iff (rst)
      s1_en[w] |=> (s2_en[w] && s2_addr[w] == $past(s1_addr[w])))
      else $error("stage 1 write on port %0d did not reach stage 2 intact", w);

    a_s2_drops: assert property (@(posedge clk) disable iff (rst)
      !s1_en[w] |=> !s2_en[w])
      else $error("stage 2 enable on port %0d set without a stage 1 write", w);
  end

endmodule

bind write_pipe regfile_chk #(.num_write(num_write)) u_chk (
  .clk     (clk),
  .rst     (rst),
  .s1_en   (s1_en),
  .s1_addr (s1_addr),
  .s2_en   (s2_en),
  .s2_addr (s2_addr)
);

// File: verilog/regfile_top.sv
module regfile_top #(
  parameter int num_read  = 2,
  parameter int num_write = 2
) (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic [num_write-1:0]                   wr_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr,
  input  regfile_pkg::data_t      [num_write-1:0] wr_data,

  input  regfile_pkg::preg_addr_t [num_read-1:0]  rd_addr,
  input  logic [num_read-1:0]                    rd_const_en,
  input  regfile_pkg::data_t      [num_read-1:0]  rd_const,
  input  logic [num_read-1:0]                    rd_arch,
  input  regfile_pkg::areg_addr_t [num_read-1:0]  rd_arch_addr,
  output regfile_pkg::data_t      [num_read-1:0]  rd_data,

  input  logic                                   ret_en,
  input  regfile_pkg::preg_addr_t                 ret_preg,
  input  regfile_pkg::areg_addr_t                 ret_areg
);

  logic [num_write-1:0]                   s1_en;
  regfile_pkg::preg_addr_t [num_write-1:0] s1_addr;
  regfile_pkg::data_t      [num_write-1:0] s1_data;
  logic [num_write-1:0]                   s2_en;
  regfile_pkg::preg_addr_t [num_write-1:0] s2_addr;
  regfile_pkg::data_t      [num_write-1:0] s2_data;

  regfile_pkg::data_t [num_read:0]   ram_data; // top entry is the retire port.
  regfile_pkg::data_t [num_read-1:0] arch_data;

  write_pipe #(.num_write(num_write)) u_write_pipe (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .s1_en   (s1_en),
    .s1_addr (s1_addr),
    .s1_data (s1_data),
    .s2_en   (s2_en),
    .s2_addr (s2_addr),
    .s2_data (s2_data)
  );

  preg_ram #(.num_ports(num_read + 1), .num_write(num_write)) u_preg_ram (
    .clk      (clk),
    .s2_en    (s2_en),
    .s2_addr  (s2_addr),
    .s2_data  (s2_data),
    .rd_addr  ({ret_preg, rd_addr}),
    .ram_data (ram_data)
  );

  retire_unit #(.num_read(num_read), .num_write(num_write)) u_retire_unit (
    .clk       (clk),
    .rst       (rst),
    .ret_en    (ret_en),
    .ret_preg  (ret_preg),
    .ret_areg  (ret_areg),
    .ram_data  (ram_data[num_read]),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .s1_en     (s1_en),
    .s1_addr   (s1_addr),
    .s1_data   (s1_data),
    .s2_en     (s2_en),
    .s2_addr   (s2_addr),
    .s2_data   (s2_data),
    .arch_addr (rd_arch_addr),
    .arch_data (arch_data)
  );

  for (genvar i = 0; i < num_read; i++) begin : g_rd
    operand_port #(.num_write(num_write)) u_operand_port (
      .clk       (clk),
      .addr      (rd_addr[i]),
      .const_en  (rd_const_en[i]),
      .const_val (rd_const[i]),
      .arch      (rd_arch[i]),
      .arch_data (arch_data[i]),
      .ram_data  (ram_data[i]),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .s1_en     (s1_en),
      .s1_addr   (s1_addr),
      .s1_data   (s1_data),
      .s2_en     (s2_en),
      .s2_addr   (s2_addr),
      .s2_data   (s2_data),
      .data      (rd_data[i])
    );
  end

endmodule

// File: verilog/retire_unit.sv
module retire_unit #(
  parameter int num_read  = 2,
  parameter int num_write = 2
) (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic                                   ret_en,
  input  regfile_pkg::preg_addr_t                 ret_preg,
  input  regfile_pkg::areg_addr_t                 ret_areg,
  input  regfile_pkg::data_t                      ram_data,

  input  logic [num_write-1:0]                   wr_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr,
  input  regfile_pkg::data_t      [num_write-1:0] wr_data,
  input  logic [num_write-1:0]                   s1_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s1_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s1_data,
  input  logic [num_write-1:0]                   s2_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s2_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s2_data,

  input  regfile_pkg::areg_addr_t [num_read-1:0]  arch_addr,
  output regfile_pkg::data_t      [num_read-1:0]  arch_data
);

  regfile_pkg::data_t      ret_data;
  logic                    ret_en_q;
  regfile_pkg::areg_addr_t ret_areg_q;
  regfile_pkg::data_t      arf [regfile_pkg::num_aregs];

  read_bypass #(.num_write(num_write)) u_read_bypass (
    .clk      (clk),
    .addr     (ret_preg),
    .ram_data (ram_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .s1_en    (s1_en),
    .s1_addr  (s1_addr),
    .s1_data  (s1_data),
    .s2_en    (s2_en),
    .s2_addr  (s2_addr),
    .s2_data  (s2_data),
    .data     (ret_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_en_q <= 1'b0;
    end else begin
      ret_en_q <= ret_en;
    end
    ret_areg_q <= ret_areg;
  end

  // retired file, written one edge after the retire is sampled.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < regfile_pkg::num_aregs; a++) begin
        arf[a] <= '0;
      end
    end else if (ret_en_q) begin
      arf[ret_areg_q] <= ret_data;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < num_read; p++) begin
      arch_data[p] <= arf[arch_addr[p]]; // no bypass on this file.
    end
  end

endmodule

// File: verilog/operand_port.sv
module operand_port #(
  parameter int num_write = 2
) (
  input  logic                                   clk,

  input  regfile_pkg::preg_addr_t                 addr,
  input  logic                                   const_en,
  input  regfile_pkg::data_t                      const_val,
  input  logic                                   arch,
  input  regfile_pkg::data_t                      arch_data,
  input  regfile_pkg::data_t                      ram_data,

  input  logic [num_write-1:0]                   wr_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr,
  input  regfile_pkg::data_t      [num_write-1:0] wr_data,
  input  logic [num_write-1:0]                   s1_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s1_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s1_data,
  input  logic [num_write-1:0]                   s2_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s2_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s2_data,

  output regfile_pkg::data_t                      data
);

  regfile_pkg::data_t phys_data;
  logic               const_en_q;
  regfile_pkg::data_t const_val_q;
  logic               arch_q;

  read_bypass #(.num_write(num_write)) u_read_bypass (
    .clk      (clk),
    .addr     (addr),
    .ram_data (ram_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .s1_en    (s1_en),
    .s1_addr  (s1_addr),
    .s1_data  (s1_data),
    .s2_en    (s2_en),
    .s2_addr  (s2_addr),
    .s2_data  (s2_data),
    .data     (phys_data)
  );

  // sampled with the address so all three sources line up.
  always_ff @(posedge clk) begin
    const_en_q  <= const_en;
    const_val_q <= const_val;
    arch_q      <= arch;
  end

  assign data = const_en_q ? const_val_q : (arch_q ? arch_data : phys_data);

endmodule

// File: verilog/read_bypass.sv
module read_bypass #(
  parameter int num_write = 2
) (
  input  logic                                   clk,

  input  regfile_pkg::preg_addr_t                 addr,
  input  regfile_pkg::data_t                      ram_data,

  input  logic [num_write-1:0]                   wr_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr,
  input  regfile_pkg::data_t      [num_write-1:0] wr_data,

  input  logic [num_write-1:0]                   s1_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s1_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s1_data,

  input  logic [num_write-1:0]                   s2_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s2_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s2_data,

  output regfile_pkg::data_t                      data
);

  logic               byp_hit;
  regfile_pkg::data_t byp_val;
  logic               hit_q;
  regfile_pkg::data_t val_q;

  // oldest layer first, so each newer match overrides the one before.
  always_comb begin
    byp_hit = 1'b0;
    byp_val = '0;
    for (int w = 0; w < num_write; w++) begin
      if (s2_en[w] && s2_addr[w] == addr) begin
        byp_hit = 1'b1;
        byp_val = s2_data[w];
      end
    end
    for (int w = 0; w < num_write; w++) begin
      if (s1_en[w] && s1_addr[w] == addr) begin
        byp_hit = 1'b1;
        byp_val = s1_data[w];
      end
    end
    for (int w = 0; w < num_write; w++) begin
      if (wr_en[w] && wr_addr[w] == addr) begin
        byp_hit = 1'b1;
        byp_val = wr_data[w]; // same-edge write, newest of all.
      end
    end
  end

  always_ff @(posedge clk) begin
    hit_q <= byp_hit;
    val_q <= byp_val;
  end

  assign data = hit_q ? val_q : ram_data;

endmodule

// File: verilog/preg_ram.sv
module preg_ram #(
  parameter int num_ports = 3,
  parameter int num_write = 2
) (
  input  logic                                   clk,

  input  logic [num_write-1:0]                   s2_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] s2_addr,
  input  regfile_pkg::data_t      [num_write-1:0] s2_data,

  input  regfile_pkg::preg_addr_t [num_ports-1:0] rd_addr,
  output regfile_pkg::data_t      [num_ports-1:0] ram_data
);

  regfile_pkg::data_t mem [regfile_pkg::num_pregs];

  // higher write port goes last, so it wins on a shared address.
  always_ff @(posedge clk) begin
    for (int w = 0; w < num_write; w++) begin
      if (s2_en[w]) begin
        mem[s2_addr[w]] <= s2_data[w];
      end
    end
  end

  // registered reads see the array before this edge's stage 2 write.
  always_ff @(posedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      ram_data[p] <= mem[rd_addr[p]];
    end
  end

endmodule

// File: verilog/write_pipe.sv
module write_pipe #(
  parameter int num_write = 2
) (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic [num_write-1:0]                   wr_en,
  input  regfile_pkg::preg_addr_t [num_write-1:0] wr_addr,
  input  regfile_pkg::data_t      [num_write-1:0] wr_data,

  output logic [num_write-1:0]                   s1_en,
  output regfile_pkg::preg_addr_t [num_write-1:0] s1_addr,
  output regfile_pkg::data_t      [num_write-1:0] s1_data,

  output logic [num_write-1:0]                   s2_en,
  output regfile_pkg::preg_addr_t [num_write-1:0] s2_addr,
  output regfile_pkg::data_t      [num_write-1:0] s2_data
);

  // stage valid bits.
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_en <= '0;
      s2_en <= '0;
    end else begin
      s1_en <= wr_en;
      s2_en <= s1_en;
    end
  end

  // address and data only move along with their enable.
  always_ff @(posedge clk) begin
    for (int w = 0; w < num_write; w++) begin
      if (wr_en[w]) begin
        s1_addr[w] <= wr_addr[w];
        s1_data[w] <= wr_data[w];
      end
      if (s1_en[w]) begin
        s2_addr[w] <= s1_addr[w];
        s2_data[w] <= s1_data[w]; // lands in the array next edge.
      end
    end
  end

endmodule

// File: verilog/regfile_pkg.sv
package regfile_pkg;

  localparam int data_width = 32;
  localparam int num_pregs  = 64;
  localparam int num_aregs  = 16;

  localparam int preg_addr_width = $clog2(num_pregs);
  localparam int areg_addr_width = $clog2(num_aregs);

  // one register value.
  typedef logic [data_width-1:0] data_t;

  // physical register index, 6 bits.
  typedef logic [preg_addr_width-1:0] preg_addr_t;

  // architectural register index, 4 bits.
  typedef logic [areg_addr_width-1:0] areg_addr_t;

endpackage
